//--- include/vector_mac_macros.svh
/* Register map and widths of the MAC unit. Offsets are byte addresses
   on a 5-bit bus, word aligned. */
`ifndef VECTOR_MAC_MACROS_SVH
`define VECTOR_MAC_MACROS_SVH

// Data path and bus widths
`define VMAC_DATA_W      32
`define VMAC_ADDR_W      5

// Register offsets
`define VMAC_REG_OPA     5'h00
`define VMAC_REG_OPB     5'h04
`define VMAC_REG_ACC     5'h08
`define VMAC_REG_CTRL    5'h0C
`define VMAC_REG_STATUS  5'h10

// Q31 saturation limits and the only AXI response used
`define VMAC_Q31_MAX     32'h7FFFFFFF
`define VMAC_Q31_MIN     32'h80000000
`define VMAC_RESP_OKAY   2'b00

`endif

//--- hdl/vector_mac_pkg.sv
/* Types shared by the MAC blocks. Needs include/ on the include path
   for the width macros. */
`default_nettype none

`include "vector_mac_macros.svh"

package vector_mac_pkg;

    // Q31 data word, also used for raw register contents
    typedef logic [`VMAC_DATA_W-1:0] q31_t;

    // Doubled product window, bits 64 down to 16 of the 65-bit result
    typedef logic [64:16] imul_result_t;

    // Byte address on the register bus
    typedef logic [`VMAC_ADDR_W-1:0] axil_addr_t;

    // Operation code, the unused value 3 behaves as MUL32X32
    typedef enum logic [1:0] {
        MUL32X32 = 2'd0,
        MUL32X16 = 2'd1,
        SAT63    = 2'd2
    } iacc_uops_t;

    // Controller sequence, one operation at a time
    typedef enum logic [1:0] {
        IDLE,
        MULTIPLY,
        ACCUMULATE
    } mac_state_t;

    // Command from the register block, start is a single-cycle pulse
    typedef struct packed {
        logic       start;
        iacc_uops_t op;
        q31_t       operand_a;
        q31_t       operand_b;
    } mac_cmd_t;

    // Live state of the controller, read back over the bus
    typedef struct packed {
        logic busy;
        logic overflow;
        q31_t acc;
    } mac_status_t;

endpackage : vector_mac_pkg

`default_nettype wire

//--- hdl/integer_multiplier.sv
/* Signed multiplier with one register stage. Operands must be stable
   in the capture cycle, no rounding is applied. */
`timescale 1ns/100ps
`default_nettype none

`include "vector_mac_macros.svh"

module integer_multiplier import vector_mac_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         capture_i,
    input  iacc_uops_t   operation_i,
    input  q31_t         operand_a_i,
    input  q31_t         operand_b_i,
    output imul_result_t imul_result_o
);

    // --------------------
    // Operand selection
    // --------------------

    logic signed [`VMAC_DATA_W-1:0]   mul_a;
    logic signed [`VMAC_DATA_W-1:0]   mul_b;
    logic signed [2*`VMAC_DATA_W-1:0] product;
    logic        [2*`VMAC_DATA_W:0]   product_x2;
    imul_result_t                     imul_result_q;

    always_comb begin
        mul_a = operand_a_i;
        // For the 32x16 mode only the low half of B counts, taken as Q15
        if (operation_i == MUL32X16) begin
            mul_b = {{16{operand_b_i[15]}}, operand_b_i[15:0]};
        end else begin
            mul_b = operand_b_i;
        end
    end

    // Full signed product, exact in 64 bits
    assign product = mul_a * mul_b;

    // Doubling drops the redundant sign bit of a Q31 x Q31 product
    // The Q31 result of the 32x32 case then sits in bits 63 to 32
    // A Q15 multiplier leaves its Q31 result in bits 47 to 16 instead
    assign product_x2 = {product, 1'b0};

    // --------------------
    // Result register
    // --------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            imul_result_q <= '0;
        end else if (capture_i) begin
            imul_result_q <= product_x2[64:16];
        end
    end

    assign imul_result_o = imul_result_q;

endmodule : integer_multiplier

`default_nettype wire

//--- hdl/integer_accumulator.sv
/* Combinational Q31 accumulate with saturation. The product window is
   truncated, never rounded. */
`timescale 1ns/100ps
`default_nettype none

`include "vector_mac_macros.svh"

module integer_accumulator import vector_mac_pkg::*; (
    // Current accumulator contents
    input  q31_t         reg_accumulator_i,
    // Doubled product window from the multiplier
    input  imul_result_t imul_result_i,
    // Operation in progress
    input  iacc_uops_t   operation_i,
    // Saturated result
    output q31_t         result_o,
    // Set when the result was clamped
    output logic         overflow_flag_o
);

    // --------------------
    // Adder
    // --------------------

    q31_t                  addend_a;
    q31_t                  addend_b;
    logic [`VMAC_DATA_W:0] sum;

    always_comb begin
        case (operation_i)
            MUL32X16: begin
                addend_a = reg_accumulator_i;
                addend_b = imul_result_i[47:16];
            end
            SAT63: begin
                // The adder is unused, the product goes straight through
                addend_a = '0;
                addend_b = '0;
            end
            default: begin
                // MUL32X32 and the spare code 3
                addend_a = reg_accumulator_i;
                addend_b = imul_result_i[63:32];
            end
        endcase
    end

    // Both addends are sign extended, so bit 32 holds the true sign
    assign sum = {addend_a[`VMAC_DATA_W-1], addend_a} + {addend_b[`VMAC_DATA_W-1], addend_b};

    // --------------------
    // Saturation
    // --------------------

    always_comb begin
        if (operation_i == SAT63) begin
            // Only -1.0 * -1.0 reaches here, bits 64 and 63 then differ
            if (imul_result_i[64] ^ imul_result_i[63]) begin
                result_o        = imul_result_i[64] ? `VMAC_Q31_MIN : `VMAC_Q31_MAX;
                overflow_flag_o = 1'b1;
            end else begin
                result_o        = imul_result_i[63:32];
                overflow_flag_o = 1'b0;
            end
        end else begin
            // A sign bit that disagrees with the MSB means the sum left Q31
            if (sum[`VMAC_DATA_W] ^ sum[`VMAC_DATA_W-1]) begin
                // The true sign picks the side to clamp to
                result_o        = sum[`VMAC_DATA_W] ? `VMAC_Q31_MIN : `VMAC_Q31_MAX;
                overflow_flag_o = 1'b1;
            end else begin
                result_o        = sum[`VMAC_DATA_W-1:0];
                overflow_flag_o = 1'b0;
            end
        end
    end

endmodule : integer_accumulator

`default_nettype wire

//--- hdl/mac_controller.sv
/* Sequences one MAC operation at a time, busy for two cycles. Loads
   and overflow clears arriving while busy are dropped. */
`timescale 1ns/100ps
`default_nettype none

module mac_controller import vector_mac_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  mac_cmd_t    cmd_i,
    input  logic        acc_load_i,
    input  q31_t        acc_load_data_i,
    input  logic        ovf_clear_i,
    input  q31_t        acc_result_i,
    input  logic        acc_overflow_i,
    output logic        mul_capture_o,
    output iacc_uops_t  mul_op_o,
    output mac_status_t status_o
);

    mac_state_t state_q;
    mac_state_t state_d;
    iacc_uops_t op_q;
    q31_t       acc_q;
    logic       ovf_q;

    // --------------------
    // FSM
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_i.start) begin
                    state_d = MULTIPLY;
                end
            end
            // The multiplier registers the product at the end of this state
            MULTIPLY:   state_d = ACCUMULATE;
            ACCUMULATE: state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            op_q    <= MUL32X32;
        end else begin
            state_q <= state_d;
            // The op stays latched until the next start
            if (state_q == IDLE && cmd_i.start) begin
                op_q <= cmd_i.op;
            end
        end
    end

    // --------------------
    // Accumulator and flag
    // --------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc_q <= '0;
            ovf_q <= 1'b0;
        end else if (state_q == ACCUMULATE) begin
            acc_q <= acc_result_i;
            // Sticky until software writes a clear
            ovf_q <= ovf_q | acc_overflow_i;
        end else if (state_q == IDLE) begin
            if (acc_load_i) begin
                acc_q <= acc_load_data_i;
            end
            if (ovf_clear_i) begin
                ovf_q <= 1'b0;
            end
        end
    end

    assign mul_capture_o     = (state_q == MULTIPLY);
    assign mul_op_o          = op_q;
    assign status_o.busy     = (state_q != IDLE);
    assign status_o.overflow = ovf_q;
    assign status_o.acc      = acc_q;

endmodule : mac_controller

`default_nettype wire

//--- hdl/axil_mac_regs.sv
/* AXI4-Lite register slave, OKAY responses only and no byte strobes.
   Every write is stalled while an operation is pending or running. */
`timescale 1ns/100ps
`default_nettype none

`include "vector_mac_macros.svh"

module axil_mac_regs import vector_mac_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    // Write address and data
    input  logic        awvalid_i,
    output logic        awready_o,
    input  axil_addr_t  awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  q31_t        wdata_i,
    // Write response
    output logic        bvalid_o,
    input  logic        bready_i,
    output logic [1:0]  bresp_o,
    // Read address and data
    input  logic        arvalid_i,
    output logic        arready_o,
    input  axil_addr_t  araddr_i,
    output logic        rvalid_o,
    input  logic        rready_i,
    output q31_t        rdata_o,
    output logic [1:0]  rresp_o,
    // Controller side
    input  mac_status_t status_i,
    output mac_cmd_t    cmd_o,
    output logic        acc_load_o,
    output q31_t        acc_load_data_o,
    output logic        ovf_clear_o
);

    logic       aw_done_q, w_done_q, bvalid_q, rvalid_q;
    axil_addr_t awaddr_q;
    q31_t       wdata_q, rdata_q, rd_mux;
    logic       write_stall, aw_hs, w_hs, ar_hs, wr_fire;
    axil_addr_t wr_addr;
    q31_t       wr_data;
    q31_t       opa_q, opb_q, load_data_q;
    iacc_uops_t op_q;
    logic       start_q, load_q, clear_q;

    // --------------------
    // Write channels
    // --------------------

    // The operands feed the multiplier directly, so no register may change
    // until the controller is back in IDLE
    assign write_stall = status_i.busy | start_q;
    assign awready_o   = ~aw_done_q & ~bvalid_q & ~write_stall;
    assign wready_o    = ~w_done_q & ~bvalid_q & ~write_stall;
    assign aw_hs       = awvalid_i & awready_o;
    assign w_hs        = wvalid_i & wready_o;

    // Address and data may arrive in either order, the half that came
    // first is held until the other one completes
    assign wr_addr = aw_done_q ? awaddr_q : awaddr_i;
    assign wr_data = w_done_q ? wdata_q : wdata_i;
    assign wr_fire = (aw_hs | aw_done_q) & (w_hs | w_done_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            bvalid_q  <= 1'b0;
        end else begin
            if (wr_fire) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                if (aw_hs) aw_done_q <= 1'b1;
                if (w_hs)  w_done_q  <= 1'b1;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) awaddr_q <= awaddr_i;
        if (w_hs)  wdata_q  <= wdata_i;
        if (wr_fire && wr_addr == `VMAC_REG_ACC) load_data_q <= wr_data;
    end

    // --------------------
    // Register decode
    // --------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            opa_q   <= '0;
            opb_q   <= '0;
            op_q    <= MUL32X32;
            start_q <= 1'b0;
            load_q  <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            // Start, load and clear are single-cycle pulses
            start_q <= 1'b0;
            load_q  <= 1'b0;
            clear_q <= 1'b0;
            if (wr_fire) begin
                case (wr_addr)
                    `VMAC_REG_OPA:    opa_q <= wr_data;
                    `VMAC_REG_OPB:    opb_q <= wr_data;
                    `VMAC_REG_ACC:    load_q <= 1'b1;
                    `VMAC_REG_CTRL: begin
                        op_q    <= iacc_uops_t'(wr_data[1:0]);
                        start_q <= 1'b1;
                    end
                    `VMAC_REG_STATUS: clear_q <= wr_data[1];
                    default: ;
                endcase
            end
        end
    end

    // --------------------
    // Read channel
    // --------------------

    assign arready_o = ~rvalid_q;
    assign ar_hs     = arvalid_i & arready_o;

    always_comb begin
        case (araddr_i)
            `VMAC_REG_OPA:    rd_mux = opa_q;
            `VMAC_REG_OPB:    rd_mux = opb_q;
            `VMAC_REG_ACC:    rd_mux = status_i.acc;
            `VMAC_REG_CTRL:   rd_mux = {{(`VMAC_DATA_W-2){1'b0}}, op_q};
            `VMAC_REG_STATUS: rd_mux = {{(`VMAC_DATA_W-2){1'b0}}, status_i.overflow, status_i.busy};
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else if (ar_hs) begin
            rvalid_q <= 1'b1;
        end else if (rready_i) begin
            rvalid_q <= 1'b0;
        end
    end

    // Read data is sampled at the address handshake
    always_ff @(posedge clk_i) begin
        if (ar_hs) rdata_q <= rd_mux;
    end

    assign bvalid_o        = bvalid_q;
    assign bresp_o         = `VMAC_RESP_OKAY;
    assign rvalid_o        = rvalid_q;
    assign rdata_o         = rdata_q;
    assign rresp_o         = `VMAC_RESP_OKAY;
    assign cmd_o           = '{start: start_q, op: op_q, operand_a: opa_q, operand_b: opb_q};
    assign acc_load_o      = load_q;
    assign acc_load_data_o = load_data_q;
    assign ovf_clear_o     = clear_q;

endmodule : axil_mac_regs

`default_nettype wire

//--- hdl/vector_mac_top.sv
/* Single-lane Q31 MAC behind an AXI4-Lite slave. Poll STATUS busy
   after a start, a new start is held off until it clears. */
`timescale 1ns/100ps
`default_nettype none

module vector_mac_top import vector_mac_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       awvalid_i,
    output logic       awready_o,
    input  axil_addr_t awaddr_i,
    input  logic       wvalid_i,
    output logic       wready_o,
    input  q31_t       wdata_i,
    output logic       bvalid_o,
    input  logic       bready_i,
    output logic [1:0] bresp_o,
    input  logic       arvalid_i,
    output logic       arready_o,
    input  axil_addr_t araddr_i,
    output logic       rvalid_o,
    input  logic       rready_i,
    output q31_t       rdata_o,
    output logic [1:0] rresp_o
);

    mac_cmd_t     cmd;
    mac_status_t  status;
    logic         acc_load, ovf_clear, mul_capture, acc_overflow;
    q31_t         acc_load_data, acc_result;
    iacc_uops_t   mul_op;
    imul_result_t imul_result;

    // --------------------
    // Bus side
    // --------------------

    axil_mac_regs axil_mac_regs_i (
        .clk_i, .rst_i,
        .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i,
        .bvalid_o, .bready_i, .bresp_o,
        .arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i, .rdata_o, .rresp_o,
        .status_i (status), .cmd_o (cmd),
        .acc_load_o (acc_load), .acc_load_data_o (acc_load_data), .ovf_clear_o (ovf_clear)
    );

    // --------------------
    // Data path
    // --------------------

    mac_controller mac_controller_i (
        .clk_i, .rst_i, .cmd_i (cmd),
        .acc_load_i (acc_load), .acc_load_data_i (acc_load_data), .ovf_clear_i (ovf_clear),
        .acc_result_i (acc_result), .acc_overflow_i (acc_overflow),
        .mul_capture_o (mul_capture), .mul_op_o (mul_op), .status_o (status)
    );

    // Operands come straight from the command, they are frozen while busy
    integer_multiplier integer_multiplier_i (
        .clk_i, .rst_i, .capture_i (mul_capture), .operation_i (mul_op),
        .operand_a_i (cmd.operand_a), .operand_b_i (cmd.operand_b),
        .imul_result_o (imul_result)
    );

    integer_accumulator integer_accumulator_i (
        .reg_accumulator_i (status.acc), .imul_result_i (imul_result),
        .operation_i (mul_op), .result_o (acc_result), .overflow_flag_o (acc_overflow)
    );

endmodule : vector_mac_top

`default_nettype wire

//--- verif/tb_vector_mac.sv
/* Testbench for the MAC unit over AXI4-Lite, bready and rready held high.
   Expected ACC and overflow come from a 65-bit model of the Q31 rules. */
`timescale 1ns/100ps
`default_nettype none

`include "vector_mac_macros.svh"

module tb_vector_mac import vector_mac_pkg::*; ();

    // Enough for roughly ten times the cycles that the tests need
    localparam int cycle_limit = 20000;

    logic       clk_i;
    logic       rst_i;
    logic       awvalid_i;
    logic       awready_o;
    axil_addr_t awaddr_i;
    logic       wvalid_i;
    logic       wready_o;
    q31_t       wdata_i;
    logic       bvalid_o;
    logic       bready_i;
    logic [1:0] bresp_o;
    logic       arvalid_i;
    logic       arready_o;
    axil_addr_t araddr_i;
    logic       rvalid_o;
    logic       rready_i;
    q31_t       rdata_o;
    logic [1:0] rresp_o;

    int   cycle_count = 0;
    int   checks = 0;
    int   errors = 0;
    int   write_wait;
    q31_t model_acc;
    logic model_ovf;

    vector_mac_top vector_mac_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Stops a run that hangs on a handshake or on the busy poll
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run reached %0d cycles before the tests finished", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // --------------------
    // Reference model
    // --------------------

    // Returns the overflow flag above the 32-bit result
    function automatic logic [32:0] model_mac(input iacc_uops_t op, input q31_t acc,
                                              input q31_t a, input q31_t b);
        logic signed [64:0] ext_a;
        logic signed [64:0] ext_b;
        logic signed [64:0] dbl;
        logic [31:0]        slice;
        logic [32:0]        sum;
        logic [32:0]        res;
        ext_a = {{33{a[31]}}, a};
        // A Q15 multiplier is the sign-extended low half of B
        if (op == MUL32X16) begin
            ext_b = {{49{b[15]}}, b[15:0]};
        end else begin
            ext_b = {{33{b[31]}}, b};
        end
        dbl = ext_a * ext_b;
        dbl = dbl <<< 1;
        if (op == SAT63) begin
            // The prior ACC plays no part here
            if (dbl[64] != dbl[63]) begin
                res = {1'b1, dbl[64] ? 32'h80000000 : 32'h7FFFFFFF};
            end else begin
                res = {1'b0, dbl[63:32]};
            end
        end else begin
            slice = (op == MUL32X16) ? dbl[47:16] : dbl[63:32];
            sum   = {acc[31], acc} + {slice[31], slice};
            if (sum[32] != sum[31]) begin
                res = {1'b1, sum[32] ? 32'h80000000 : 32'h7FFFFFFF};
            end else begin
                res = {1'b0, sum[31:0]};
            end
        end
        return res;
    endfunction

    // --------------------
    // Bus tasks
    // --------------------

    // The slave answers every transfer with OKAY
    task automatic check_resp(input string channel, input logic [1:0] resp);
        checks++;
        assert (resp === 2'b00) else begin
            errors++;
            $display("ERROR at %0t ns: %s response 0x%0h, expected OKAY", $time, channel, resp);
        end
    endtask

    // Every task starts and ends 2 ns after a rising edge, ready and valid
    // are sampled at the falling edge where nothing changes
    task automatic axil_write(input axil_addr_t addr, input q31_t data);
        logic       aw_now;
        logic       w_now;
        logic       b_seen;
        logic [1:0] b_resp;
        write_wait = 0;
        b_seen     = 1'b0;
        b_resp     = 2'b00;
        awaddr_i   = addr;
        wdata_i    = data;
        awvalid_i  = 1'b1;
        wvalid_i   = 1'b1;
        while (awvalid_i || wvalid_i) begin
            @(negedge clk_i);
            aw_now = awvalid_i & awready_o;
            w_now  = wvalid_i & wready_o;
            if (!aw_now && !w_now) write_wait++;
            @(posedge clk_i);
            #2;
            if (aw_now) awvalid_i = 1'b0;
            if (w_now) wvalid_i = 1'b0;
        end
        while (!b_seen) begin
            @(negedge clk_i);
            b_seen = bvalid_o;
            b_resp = bresp_o;
            @(posedge clk_i);
            #2;
        end
        check_resp("write", b_resp);
    endtask

    task automatic axil_read(input axil_addr_t addr, output q31_t data);
        logic       ar_now;
        logic       r_now;
        logic [1:0] r_resp;
        ar_now    = 1'b0;
        r_now     = 1'b0;
        r_resp    = 2'b00;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        while (!ar_now) begin
            @(negedge clk_i);
            ar_now = arready_o;
            @(posedge clk_i);
            #2;
        end
        arvalid_i = 1'b0;
        while (!r_now) begin
            @(negedge clk_i);
            r_now  = rvalid_o;
            data   = rdata_o;
            r_resp = rresp_o;
            @(posedge clk_i);
            #2;
        end
        check_resp("read", r_resp);
    endtask

    // --------------------
    // Test helpers
    // --------------------

    task automatic check_value(input string what, input q31_t got, input q31_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic wait_idle();
        q31_t st;
        st = 32'h1;
        while (st[0]) axil_read(`VMAC_REG_STATUS, st);
    endtask

    task automatic clear_overflow();
        axil_write(`VMAC_REG_STATUS, 32'h2);
        model_ovf = 1'b0;
    endtask

    // Loads ACC, runs one operation to completion and steps the model
    task automatic run_op(input iacc_uops_t op, input q31_t acc0, input q31_t a, input q31_t b);
        logic [32:0] res;
        axil_write(`VMAC_REG_ACC, acc0);
        axil_write(`VMAC_REG_OPA, a);
        axil_write(`VMAC_REG_OPB, b);
        axil_write(`VMAC_REG_CTRL, {30'd0, op});
        wait_idle();
        res       = model_mac(op, acc0, a, b);
        model_acc = res[31:0];
        model_ovf = model_ovf | res[32];
    endtask

    task automatic compare_state(input string what);
        q31_t got;
        axil_read(`VMAC_REG_ACC, got);
        check_value({what, " ACC"}, got, model_acc);
        axil_read(`VMAC_REG_STATUS, got);
        check_value({what, " STATUS"}, got, {30'd0, model_ovf, 1'b0});
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("PASS  %s", name);
        end else begin
            $display("FAIL  %s (%0d errors)", name, errors - errs_before);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        int          i;
        int          errs_start;
        q31_t        acc0;
        q31_t        a;
        q31_t        b;
        q31_t        got;
        logic [32:0] res;
        got       = $urandom(32'h44746a35);
        rst_i     = 1'b1;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        bready_i  = 1'b1;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        rready_i  = 1'b1;
        model_acc = '0;
        model_ovf = 1'b0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        // Reset values, then operand read-back
        errs_start = errors;
        axil_read(`VMAC_REG_STATUS, got);
        check_value("reset STATUS", got, 32'h0);
        axil_read(`VMAC_REG_ACC, got);
        check_value("reset ACC", got, 32'h0);
        axil_read(`VMAC_REG_OPA, got);
        check_value("reset OPA", got, 32'h0);
        a = $urandom;
        b = $urandom;
        axil_write(`VMAC_REG_OPA, a);
        axil_write(`VMAC_REG_OPB, b);
        axil_read(`VMAC_REG_OPA, got);
        check_value("OPA read-back", got, a);
        axil_read(`VMAC_REG_OPB, got);
        check_value("OPB read-back", got, b);
        report_test("1 reset and operand registers", errs_start);

        // Sticky overflow collects over the whole series
        errs_start = errors;
        clear_overflow();
        for (i = 0; i < 50; i++) begin
            run_op(MUL32X32, $urandom, $urandom, $urandom);
            compare_state("MUL32X32");
        end
        report_test("2 MUL32X32 accumulate", errs_start);

        // Same low half with two different high halves of B
        errs_start = errors;
        clear_overflow();
        for (i = 0; i < 20; i++) begin
            acc0 = $urandom;
            a    = $urandom;
            b    = $urandom;
            run_op(MUL32X16, acc0, a, b);
            compare_state("MUL32X16");
            b[31:16] = $urandom;
            run_op(MUL32X16, acc0, a, b);
            compare_state("MUL32X16 high bits");
        end
        report_test("3 MUL32X16 low half only", errs_start);

        // The only SAT63 overflow is -1.0 times -1.0
        errs_start = errors;
        clear_overflow();
        run_op(SAT63, $urandom, 32'h80000000, 32'h80000000);
        axil_read(`VMAC_REG_ACC, got);
        check_value("SAT63 corner ACC", got, 32'h7FFFFFFF);
        axil_read(`VMAC_REG_STATUS, got);
        check_value("SAT63 corner STATUS", got, 32'h2);
        clear_overflow();
        for (i = 0; i < 20; i++) begin
            run_op(SAT63, $urandom, $urandom, $urandom);
            compare_state("SAT63");
        end
        report_test("4 SAT63 saturated product", errs_start);

        // Clamping on both sides, each followed by a flag clear
        errs_start = errors;
        clear_overflow();
        run_op(MUL32X32, 32'h7FFF0000, 32'h7FFFFFFF, 32'h7FFFFFFF);
        axil_read(`VMAC_REG_ACC, got);
        check_value("positive clamp ACC", got, 32'h7FFFFFFF);
        axil_read(`VMAC_REG_STATUS, got);
        check_value("positive clamp STATUS", got, 32'h2);
        clear_overflow();
        axil_read(`VMAC_REG_STATUS, got);
        check_value("STATUS after clear", got, 32'h0);
        run_op(MUL32X32, 32'h80010000, 32'h7FFFFFFF, 32'h80000000);
        axil_read(`VMAC_REG_ACC, got);
        check_value("negative clamp ACC", got, 32'h80000000);
        axil_read(`VMAC_REG_STATUS, got);
        check_value("negative clamp STATUS", got, 32'h2);
        clear_overflow();
        axil_read(`VMAC_REG_STATUS, got);
        check_value("STATUS after clear", got, 32'h0);
        report_test("5 saturation and overflow clear", errs_start);

        // Second start goes out without polling and must stall
        errs_start = errors;
        clear_overflow();
        acc0 = $urandom;
        a    = $urandom;
        b    = $urandom;
        axil_write(`VMAC_REG_ACC, acc0);
        axil_write(`VMAC_REG_OPA, a);
        axil_write(`VMAC_REG_OPB, b);
        axil_write(`VMAC_REG_CTRL, {30'd0, MUL32X32});
        axil_write(`VMAC_REG_CTRL, {30'd0, MUL32X16});
        checks++;
        assert (write_wait > 0) else begin
            errors++;
            $display("The second CTRL write was accepted while the first operation was running");
        end
        wait_idle();
        res       = model_mac(MUL32X32, acc0, a, b);
        model_ovf = res[32];
        res       = model_mac(MUL32X16, res[31:0], a, b);
        model_acc = res[31:0];
        model_ovf = model_ovf | res[32];
        compare_state("back-to-back");
        report_test("6 back-to-back CTRL writes", errs_start);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_vector_mac

`default_nettype wire

//--- sim.f
+incdir+include
hdl/vector_mac_pkg.sv
hdl/integer_multiplier.sv
hdl/integer_accumulator.sv
hdl/mac_controller.sv
hdl/axil_mac_regs.sv
hdl/vector_mac_top.sv
verif/tb_vector_mac.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the MAC testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vector_mac \
    -f sim.f \
    -o sim_vector_mac

./obj_dir/sim_vector_mac | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
